//--- files.f
+incdir+tb
common/merge_pkg.sv
axis_fifo/axis_fifo.sv
design/frame_arbiter.sv
design/frame_stats.sv
design/axis_merge_top.sv
tb/axis_merge_tb.sv

//--- tb/merge_model.svh
`ifndef MERGE_MODEL_SVH
`define MERGE_MODEL_SVH

typedef enum int {
  FATE_GOOD,
  FATE_BAD,
  FATE_OVERFLOW
} fate_t;

// frame numbers of good frames each source still owes the output.
int exp_queue_a [$];
int exp_queue_b [$];
int exp_good [2];
int exp_bad [2];
int exp_ovf [2];

// what the input FIFO makes of a frame.
function automatic fate_t frame_fate(input int len, input bit last_user, input int fifo_depth);
  if (len > fifo_depth) begin
    return FATE_OVERFLOW;  // an over-long frame is never counted as bad.
  end
  if (last_user) begin
    return FATE_BAD;
  end
  return FATE_GOOD;
endfunction

function automatic int pending(input int src);
  return (src == 0) ? exp_queue_a.size() : exp_queue_b.size();
endfunction

function automatic int pop_expected(input int src);
  if (src == 0) begin
    return exp_queue_a.pop_front();
  end
  return exp_queue_b.pop_front();
endfunction

// runs once the last beat of frame f has been accepted.
function automatic void model_frame(input int src, input int f);
  int last_beat;
  last_beat = frame_start[src][f] + frame_len[src][f] - 1;
  case (frame_fate(frame_len[src][f], beat_user[src][last_beat], depth))
    FATE_GOOD: begin
      exp_good[src]++;
      if (src == 0) begin
        exp_queue_a.push_back(f);
      end else begin
        exp_queue_b.push_back(f);
      end
    end
    FATE_BAD: exp_bad[src]++;
    default: exp_ovf[src]++;
  endcase
endfunction

`endif

//--- tb/axis_merge_tb.sv
`timescale 1ns/1ns

module axis_merge_tb
  import merge_pkg::*;
();

  localparam int DATA_WIDTH = 8;
  localparam int N_MIXED = 24;  // good, bad and over-long frames.
  localparam int N_ALT = 4;     // short good frames per source.
  localparam int N_FRAMES = N_MIXED + N_ALT;
  localparam int MAX_BEATS = 4096;
  localparam int DRIVE_DELAY = 10;
  localparam int SETTLE_LIMIT = 20000;
  localparam int READY_RANDOM = 0;
  localparam int READY_LOW = 1;
  localparam int READY_HIGH = 2;

  logic                   clk;
  logic                   rst;
  logic [DATA_WIDTH-1:0]  s_a_tdata;
  logic                   s_a_tvalid;
  logic                   s_a_tready;
  logic                   s_a_tlast;
  logic                   s_a_tuser;
  logic [DATA_WIDTH-1:0]  s_b_tdata;
  logic                   s_b_tvalid;
  logic                   s_b_tready;
  logic                   s_b_tlast;
  logic                   s_b_tuser;
  logic [DATA_WIDTH-1:0]  m_tdata;
  logic                   m_tvalid;
  logic                   m_tready;
  logic                   m_tlast;
  source_t                m_tid;
  logic [COUNT_WIDTH-1:0] good_count_a;
  logic [COUNT_WIDTH-1:0] bad_count_a;
  logic [COUNT_WIDTH-1:0] ovf_count_a;
  logic [COUNT_WIDTH-1:0] good_count_b;
  logic [COUNT_WIDTH-1:0] bad_count_b;
  logic [COUNT_WIDTH-1:0] ovf_count_b;

  // frames of both sources, built before reset.
  int                    frame_len [2][N_FRAMES];
  int                    frame_start [2][N_FRAMES];
  int                    frame_gap [2][N_FRAMES];
  logic [DATA_WIDTH-1:0] beat_data [2][MAX_BEATS];
  bit                    beat_user [2][MAX_BEATS];

  integer seed;
  int     depth;
  int     total_beats;
  bit     plan_done;
  int     ready_mode;
  int     errors;
  int     checks;
  bit     out_frame_open;
  int     delivered [2];
  int     tid_log [$];  // source of each finished output frame.

  `include "merge_model.svh"

  axis_merge_top #(
    .DATA_WIDTH(DATA_WIDTH)
  ) DUT (
    .clk(clk), .rst(rst),
    .s_a_tdata(s_a_tdata), .s_a_tvalid(s_a_tvalid), .s_a_tready(s_a_tready),
    .s_a_tlast(s_a_tlast), .s_a_tuser(s_a_tuser),
    .s_b_tdata(s_b_tdata), .s_b_tvalid(s_b_tvalid), .s_b_tready(s_b_tready),
    .s_b_tlast(s_b_tlast), .s_b_tuser(s_b_tuser),
    .m_tdata(m_tdata), .m_tvalid(m_tvalid), .m_tready(m_tready),
    .m_tlast(m_tlast), .m_tid(m_tid),
    .good_count_a(good_count_a), .bad_count_a(bad_count_a), .ovf_count_a(ovf_count_a),
    .good_count_b(good_count_b), .bad_count_b(bad_count_b), .ovf_count_b(ovf_count_b)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ********************
  // helpers
  // ********************

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic build_stimulus();
    int src;
    int f;
    int k;
    int kind;
    int pos;
    total_beats = 0;
    for (src = 0; src < 2; src++) begin
      pos = 0;
      for (f = 0; f < N_FRAMES; f++) begin
        kind = rand_below(10);  // 0-5 good, 6-7 bad, 8 too long, 9 nearly full.
        if (f == 3) begin
          kind = 8;
        end else if (f == 4) begin
          kind = 6;
        end else if (f == 7) begin
          kind = 9;
        end
        if (f >= N_MIXED) begin
          kind = 0;
          frame_len[src][f] = 2 + rand_below(7);
        end else if (kind == 8) begin
          frame_len[src][f] = depth + 1 + rand_below(8);
        end else if (kind == 9) begin
          frame_len[src][f] = (f == 7) ? depth : depth - rand_below(4);
        end else begin
          frame_len[src][f] = 1 + rand_below(16);
        end
        frame_start[src][f] = pos;
        frame_gap[src][f] = (f >= N_MIXED) ? 0 : rand_below(4);
        for (k = 0; k < frame_len[src][f]; k++) begin
          beat_data[src][pos] = DATA_WIDTH'($random(seed));
          beat_user[src][pos] = (rand_below(2) == 1);  // ignored before the last beat.
          pos++;
        end
        if (kind == 6 || kind == 7) begin
          beat_user[src][pos-1] = 1'b1;
        end else if (kind != 8) begin
          beat_user[src][pos-1] = 1'b0;
        end
        total_beats += frame_len[src][f];
      end
    end
  endtask

  task automatic drive_beat(input int src, input bit valid, input logic [DATA_WIDTH-1:0] data,
                            input bit last, input bit user);
    if (src == 0) begin
      s_a_tvalid = valid;
      s_a_tdata = data;
      s_a_tlast = last;
      s_a_tuser = user;
    end else begin
      s_b_tvalid = valid;
      s_b_tdata = data;
      s_b_tlast = last;
      s_b_tuser = user;
    end
  endtask

  function automatic bit input_ready(input int src);
    return (src == 0) ? s_a_tready : s_b_tready;
  endfunction

  task automatic send_frames(input int src, input int first, input int stop);
    int f;
    int k;
    int pos;
    bit moved;
    for (f = first; f < stop; f++) begin
      for (k = 0; k < frame_len[src][f]; k++) begin
        pos = frame_start[src][f] + k;
        drive_beat(src, 1'b1, beat_data[src][pos], k == frame_len[src][f] - 1,
                   beat_user[src][pos]);
        moved = 1'b0;
        while (!moved) begin
          @(negedge clk);
          moved = input_ready(src);  // tready depends on FIFO state only.
          @(posedge clk);
          #DRIVE_DELAY;
        end
      end
      model_frame(src, f);
      drive_beat(src, 1'b0, '0, 1'b0, 1'b0);
      repeat (frame_gap[src][f]) begin
        @(posedge clk);
        #DRIVE_DELAY;
      end
    end
  endtask

  function automatic bit counts_match();
    return good_count_a == exp_good[0] && bad_count_a == exp_bad[0] &&
           ovf_count_a == exp_ovf[0] && good_count_b == exp_good[1] &&
           bad_count_b == exp_bad[1] && ovf_count_b == exp_ovf[1];
  endfunction

  function automatic bit drained();
    return counts_match() && pending(0) == 0 && pending(1) == 0 && !out_frame_open;
  endfunction

  task automatic wait_settled(input string phase, input bit need_drain);
    int cycles;
    cycles = 0;
    while (!(need_drain ? drained() : counts_match()) && cycles < SETTLE_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= SETTLE_LIMIT) begin
      note_failure($sformatf("%s phase did not settle within %0d cycles", phase, cycles));
    end
  endtask

  // ********************
  // output ready
  // ********************

  initial begin : drive_ready
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (ready_mode == READY_RANDOM) begin
        m_tready = (rand_below(10) < 7);
      end else begin
        m_tready = (ready_mode == READY_HIGH);
      end
    end
  end

  // ********************
  // compare
  // ********************

  initial begin : compare_output
    int cur_tid;
    int beat_idx;
    int exp_idx;
    int exp_len;
    cur_tid = 0;
    beat_idx = 0;
    exp_idx = -1;
    forever begin
      @(negedge clk);
      if (!rst && m_tvalid && m_tready) begin
        if (!out_frame_open) begin
          cur_tid = int'(m_tid);
          beat_idx = 0;
          out_frame_open = 1'b1;
          if (pending(cur_tid) == 0) begin
            exp_idx = -1;
            note_failure($sformatf("frame from source %0d arrived with none expected", cur_tid));
          end else begin
            exp_idx = pop_expected(cur_tid);
          end
        end
        check_value("m_tid", m_tid, cur_tid);  // one source per frame.
        if (exp_idx >= 0) begin
          exp_len = frame_len[cur_tid][exp_idx];
          if (beat_idx < exp_len) begin
            check_value("m_tdata", m_tdata,
                        beat_data[cur_tid][frame_start[cur_tid][exp_idx] + beat_idx]);
            check_value("m_tlast", m_tlast, beat_idx == exp_len - 1);
          end
        end
        beat_idx++;
        if (m_tlast) begin
          out_frame_open = 1'b0;
          delivered[cur_tid]++;
          tid_log.push_back(cur_tid);
        end
      end
    end
  end

  initial begin : watchdog
    wait (plan_done);
    repeat (total_beats * 40 + 2000) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish",
             total_beats * 40 + 2000);
    $display("checks: %0d  errors: %0d", checks, errors);
    $display("Test failures found");
    $finish;
  end

  // ********************
  // main sequence
  // ********************

  initial begin : main_flow
    int alt_first;
    int i;
    seed = 32'hc72c;
    rst = 1'b1;
    m_tready = 1'b0;
    ready_mode = READY_RANDOM;
    drive_beat(0, 1'b0, '0, 1'b0, 1'b0);
    drive_beat(1, 1'b0, '0, 1'b0, 1'b0);
    depth = 2 ** DUT.ADDR_WIDTH;
    build_stimulus();
    plan_done = 1'b1;
    repeat (8) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    // mixed frames with random back-pressure.
    fork
      send_frames(0, 0, N_MIXED);
      send_frames(1, 0, N_MIXED);
    join
    wait_settled("mixed", 1'b1);

    // both FIFOs fill up behind a stalled output, then drain.
    ready_mode = READY_LOW;
    @(posedge clk);
    #DRIVE_DELAY;
    alt_first = tid_log.size();
    fork
      send_frames(0, N_MIXED, N_FRAMES);
      send_frames(1, N_MIXED, N_FRAMES);
    join
    wait_settled("alternation load", 1'b0);
    ready_mode = READY_HIGH;
    wait_settled("alternation", 1'b1);
    check_value("alternation frame count", tid_log.size() - alt_first, 2 * N_ALT);
    for (i = alt_first + 1; i < tid_log.size(); i++) begin
      check_value("m_tid of next frame", tid_log[i], 1 - tid_log[i-1]);
    end

    check_value("good_count_a", good_count_a, exp_good[0]);
    check_value("bad_count_a", bad_count_a, exp_bad[0]);
    check_value("ovf_count_a", ovf_count_a, exp_ovf[0]);
    check_value("good_count_b", good_count_b, exp_good[1]);
    check_value("bad_count_b", bad_count_b, exp_bad[1]);
    check_value("ovf_count_b", ovf_count_b, exp_ovf[1]);
    check_value("good_count_a vs delivered", good_count_a, delivered[0]);
    check_value("good_count_b vs delivered", good_count_b, delivered[1]);

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- design/axis_merge_top.sv
`timescale 1ns/1ns

module axis_merge_top
  import merge_pkg::*;
#(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 6
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [DATA_WIDTH-1:0]  s_a_tdata,
  input  logic                   s_a_tvalid,
  output logic                   s_a_tready,
  input  logic                   s_a_tlast,
  input  logic                   s_a_tuser,
  input  logic [DATA_WIDTH-1:0]  s_b_tdata,
  input  logic                   s_b_tvalid,
  output logic                   s_b_tready,
  input  logic                   s_b_tlast,
  input  logic                   s_b_tuser,
  output logic [DATA_WIDTH-1:0]  m_tdata,
  output logic                   m_tvalid,
  input  logic                   m_tready,
  output logic                   m_tlast,
  output source_t                m_tid,
  output logic [COUNT_WIDTH-1:0] good_count_a,
  output logic [COUNT_WIDTH-1:0] bad_count_a,
  output logic [COUNT_WIDTH-1:0] ovf_count_a,
  output logic [COUNT_WIDTH-1:0] good_count_b,
  output logic [COUNT_WIDTH-1:0] bad_count_b,
  output logic [COUNT_WIDTH-1:0] ovf_count_b
);

  logic [DATA_WIDTH-1:0] fifo_a_tdata;
  logic                  fifo_a_tvalid;
  logic                  fifo_a_tready;
  logic                  fifo_a_tlast;
  logic [DATA_WIDTH-1:0] fifo_b_tdata;
  logic                  fifo_b_tvalid;
  logic                  fifo_b_tready;
  logic                  fifo_b_tlast;

  // status pulses, one per finished input frame.
  logic good_a;
  logic bad_a;
  logic ovf_a;
  logic good_b;
  logic bad_b;
  logic ovf_b;

  // ********************
  // input frame FIFOs
  // ********************

  axis_fifo #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_fifo_a (
    .clk            (clk),
    .rst            (rst),
    .s_tdata        (s_a_tdata),
    .s_tvalid       (s_a_tvalid),
    .s_tready       (s_a_tready),
    .s_tlast        (s_a_tlast),
    .s_tuser        (s_a_tuser),
    .m_tdata        (fifo_a_tdata),
    .m_tvalid       (fifo_a_tvalid),
    .m_tready       (fifo_a_tready),
    .m_tlast        (fifo_a_tlast),
    .status_good    (good_a),
    .status_bad     (bad_a),
    .status_overflow(ovf_a)
  );

  axis_fifo #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_fifo_b (
    .clk            (clk),
    .rst            (rst),
    .s_tdata        (s_b_tdata),
    .s_tvalid       (s_b_tvalid),
    .s_tready       (s_b_tready),
    .s_tlast        (s_b_tlast),
    .s_tuser        (s_b_tuser),
    .m_tdata        (fifo_b_tdata),
    .m_tvalid       (fifo_b_tvalid),
    .m_tready       (fifo_b_tready),
    .m_tlast        (fifo_b_tlast),
    .status_good    (good_b),
    .status_bad     (bad_b),
    .status_overflow(ovf_b)
  );

  // ********************
  // merge and counters
  // ********************

  frame_arbiter #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_arbiter (
    .clk     (clk),
    .rst     (rst),
    .a_tdata (fifo_a_tdata),
    .a_tvalid(fifo_a_tvalid),
    .a_tready(fifo_a_tready),
    .a_tlast (fifo_a_tlast),
    .b_tdata (fifo_b_tdata),
    .b_tvalid(fifo_b_tvalid),
    .b_tready(fifo_b_tready),
    .b_tlast (fifo_b_tlast),
    .m_tdata (m_tdata),
    .m_tvalid(m_tvalid),
    .m_tready(m_tready),
    .m_tlast (m_tlast),
    .m_tid   (m_tid)
  );

  frame_stats u_stats (
    .clk         (clk),
    .rst         (rst),
    .good_a      (good_a),
    .bad_a       (bad_a),
    .ovf_a       (ovf_a),
    .good_b      (good_b),
    .bad_b       (bad_b),
    .ovf_b       (ovf_b),
    .good_count_a(good_count_a),
    .bad_count_a (bad_count_a),
    .ovf_count_a (ovf_count_a),
    .good_count_b(good_count_b),
    .bad_count_b (bad_count_b),
    .ovf_count_b (ovf_count_b)
  );

endmodule

//--- design/frame_stats.sv
`timescale 1ns/1ns

module frame_stats
  import merge_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   good_a,
  input  logic                   bad_a,
  input  logic                   ovf_a,
  input  logic                   good_b,
  input  logic                   bad_b,
  input  logic                   ovf_b,
  output logic [COUNT_WIDTH-1:0] good_count_a,
  output logic [COUNT_WIDTH-1:0] bad_count_a,
  output logic [COUNT_WIDTH-1:0] ovf_count_a,
  output logic [COUNT_WIDTH-1:0] good_count_b,
  output logic [COUNT_WIDTH-1:0] bad_count_b,
  output logic [COUNT_WIDTH-1:0] ovf_count_b
);

  localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = '1;

  logic                   good_pulse [2];
  logic                   bad_pulse [2];
  logic                   ovf_pulse [2];
  logic [COUNT_WIDTH-1:0] good_cnt [2];
  logic [COUNT_WIDTH-1:0] bad_cnt [2];
  logic [COUNT_WIDTH-1:0] ovf_cnt [2];

  function automatic logic [COUNT_WIDTH-1:0] sat_inc(input logic [COUNT_WIDTH-1:0] cnt,
                                                     input logic pulse);
    if (pulse && cnt != COUNT_MAX) begin
      return cnt + 1'b1;
    end
    return cnt;  // holds at max.
  endfunction

  assign good_pulse[SRC_A] = good_a;
  assign bad_pulse[SRC_A]  = bad_a;
  assign ovf_pulse[SRC_A]  = ovf_a;
  assign good_pulse[SRC_B] = good_b;
  assign bad_pulse[SRC_B]  = bad_b;
  assign ovf_pulse[SRC_B]  = ovf_b;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < 2; s++) begin
        good_cnt[s] <= '0;
        bad_cnt[s] <= '0;
        ovf_cnt[s] <= '0;
      end
    end else begin
      for (int s = 0; s < 2; s++) begin
        good_cnt[s] <= sat_inc(good_cnt[s], good_pulse[s]);
        bad_cnt[s] <= sat_inc(bad_cnt[s], bad_pulse[s]);
        ovf_cnt[s] <= sat_inc(ovf_cnt[s], ovf_pulse[s]);
      end
    end
  end

  assign good_count_a = good_cnt[SRC_A];
  assign bad_count_a  = bad_cnt[SRC_A];
  assign ovf_count_a  = ovf_cnt[SRC_A];
  assign good_count_b = good_cnt[SRC_B];
  assign bad_count_b  = bad_cnt[SRC_B];
  assign ovf_count_b  = ovf_cnt[SRC_B];

  // a frame ends exactly one way.
  a_one_status_a: assert property (
    @(posedge clk) disable iff (rst) $onehot0({good_a, bad_a, ovf_a})
  );
  a_one_status_b: assert property (
    @(posedge clk) disable iff (rst) $onehot0({good_b, bad_b, ovf_b})
  );

endmodule

//--- design/frame_arbiter.sv
`timescale 1ns/1ns

module frame_arbiter
  import merge_pkg::*;
#(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [DATA_WIDTH-1:0] a_tdata,
  input  logic                  a_tvalid,
  output logic                  a_tready,
  input  logic                  a_tlast,
  input  logic [DATA_WIDTH-1:0] b_tdata,
  input  logic                  b_tvalid,
  output logic                  b_tready,
  input  logic                  b_tlast,
  output logic [DATA_WIDTH-1:0] m_tdata,
  output logic                  m_tvalid,
  input  logic                  m_tready,
  output logic                  m_tlast,
  output source_t               m_tid
);

  source_t               grant;       // source of the current or last frame.
  source_t               sel;
  source_t               other;
  logic                  frame_open;  // first beat passed, last not yet.
  logic                  out_ready;
  logic                  sel_valid;
  logic                  sel_last;
  logic [DATA_WIDTH-1:0] sel_data;
  logic                  take;

  assign other = (grant == SRC_A) ? SRC_B : SRC_A;

  // ********************
  // source select
  // ********************

  always_comb begin
    if (frame_open) begin
      sel = grant;  // locked until the last beat.
    end else if (a_tvalid && b_tvalid) begin
      sel = other;
    end else if (b_tvalid) begin
      sel = SRC_B;
    end else begin
      sel = SRC_A;
    end
  end

  assign sel_valid = (sel == SRC_A) ? a_tvalid : b_tvalid;
  assign sel_last  = (sel == SRC_A) ? a_tlast : b_tlast;
  assign sel_data  = (sel == SRC_A) ? a_tdata : b_tdata;

  assign out_ready = m_tready || !m_tvalid;
  assign take = sel_valid && out_ready;

  assign a_tready = out_ready && (sel == SRC_A);
  assign b_tready = out_ready && (sel == SRC_B);

  // ********************
  // output stage
  // ********************

  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= SRC_B;  // first frame goes to SRC_A.
      frame_open <= 1'b0;
      m_tvalid <= 1'b0;
    end else begin
      if (take) begin
        grant <= sel;
        frame_open <= !sel_last;
      end
      if (out_ready) begin
        m_tvalid <= sel_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      m_tdata <= sel_data;
      m_tlast <= sel_last;
      m_tid <= sel;
    end
  end

  // tid holds from the first beat of a frame to its last.
  a_grant_locked: assert property (
    @(posedge clk) disable iff (rst) m_tvalid && !m_tlast |=> $stable(m_tid)
  );

endmodule

//--- axis_fifo/axis_fifo.sv
`timescale 1ns/1ns

module axis_fifo
  import merge_pkg::*;
#(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 6
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [DATA_WIDTH-1:0] s_tdata,
  input  logic                  s_tvalid,
  output logic                  s_tready,
  input  logic                  s_tlast,
  input  logic                  s_tuser,
  output logic [DATA_WIDTH-1:0] m_tdata,
  output logic                  m_tvalid,
  input  logic                  m_tready,
  output logic                  m_tlast,
  output logic                  status_good,
  output logic                  status_bad,
  output logic                  status_overflow
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;
  localparam int WORD_WIDTH = DATA_WIDTH + 1;  // tlast rides above the data.

  logic [ADDR_WIDTH:0] wr_ptr;      // committed, end of the last good frame.
  logic [ADDR_WIDTH:0] wr_ptr_cur;  // tentative, inside the open frame.
  logic [ADDR_WIDTH:0] wr_ptr_rd;   // committed pointer as seen by the read side.
  logic [ADDR_WIDTH:0] rd_ptr;
  logic [ADDR_WIDTH:0] wr_ptr_next;
  logic [ADDR_WIDTH:0] wr_ptr_cur_next;
  logic [ADDR_WIDTH:0] used_words;

  logic [WORD_WIDTH-1:0] mem [DEPTH];
  logic [WORD_WIDTH-1:0] rd_word;
  logic                  rd_word_valid;
  logic [WORD_WIDTH-1:0] out_word;

  logic full_cur;
  logic full_wr;
  logic empty;
  logic write;
  logic read;
  logic load_out;
  logic good_next;
  logic bad_next;
  logic ovf_next;

  // ********************
  // write side
  // ********************

  // full_cur with the whole buffer taken by the open frame means overflow.
  assign full_cur = (wr_ptr_cur[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                    (wr_ptr_cur[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
  assign full_wr  = (wr_ptr_cur[ADDR_WIDTH] != wr_ptr[ADDR_WIDTH]) &&
                    (wr_ptr_cur[ADDR_WIDTH-1:0] == wr_ptr[ADDR_WIDTH-1:0]);

  // stall while older frames drain, but keep eating an over-long frame.
  assign s_tready = !full_cur || full_wr;

  always_comb begin
    write = 1'b0;
    wr_ptr_next = wr_ptr;
    wr_ptr_cur_next = wr_ptr_cur;
    good_next = 1'b0;
    bad_next = 1'b0;
    ovf_next = 1'b0;
    if (s_tvalid && s_tready) begin
      if (full_cur) begin
        // frame no longer fits, rest of it is discarded.
        if (s_tlast) begin
          wr_ptr_cur_next = wr_ptr;
          ovf_next = 1'b1;
        end
      end else begin
        write = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur + 1'b1;
        if (s_tlast) begin
          if (s_tuser == BAD_FRAME_USER) begin
            wr_ptr_cur_next = wr_ptr;  // rewind.
            bad_next = 1'b1;
          end else begin
            wr_ptr_next = wr_ptr_cur + 1'b1;  // commit.
            good_next = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      wr_ptr_cur <= '0;
      wr_ptr_rd <= '0;
      status_good <= 1'b0;
      status_bad <= 1'b0;
      status_overflow <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr_next;
      wr_ptr_cur <= wr_ptr_cur_next;
      wr_ptr_rd <= wr_ptr;
      status_good <= good_next;
      status_bad <= bad_next;
      status_overflow <= ovf_next;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_ptr_cur[ADDR_WIDTH-1:0]] <= {s_tlast, s_tdata};
    end
  end

  // ********************
  // read side
  // ********************

  assign empty = (wr_ptr_rd == rd_ptr);
  assign load_out = m_tready || !m_tvalid;
  assign read = (load_out || !rd_word_valid) && !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      rd_word_valid <= 1'b0;
      m_tvalid <= 1'b0;
    end else begin
      if (read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (load_out || !rd_word_valid) begin
        rd_word_valid <= !empty;
      end
      if (load_out) begin
        m_tvalid <= rd_word_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      rd_word <= mem[rd_ptr[ADDR_WIDTH-1:0]];  // memory read register.
    end
    if (load_out) begin
      out_word <= rd_word;  // output register.
    end
  end

  assign m_tdata = out_word[DATA_WIDTH-1:0];
  assign m_tlast = out_word[DATA_WIDTH];

  assign used_words = wr_ptr - rd_ptr;

  a_committed_bound: assert property (
    @(posedge clk) disable iff (rst) used_words <= DEPTH
  );

  // downstream relies on a held beat.
  a_output_stable: assert property (
    @(posedge clk) disable iff (rst)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast)
  );

endmodule

//--- common/merge_pkg.sv
package merge_pkg;

  // input port a frame came from, carried on the output tid.
  typedef enum logic {
    SRC_A = 1'b0,
    SRC_B = 1'b1
  } source_t;

  // tuser value on a last beat that marks the whole frame bad.
  localparam logic BAD_FRAME_USER = 1'b1;

  localparam int COUNT_WIDTH = 16;  // width of each statistics counter.

endpackage
